/* hdl/delta_pkg.sv */
package delta_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // frame and window geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int NUM_COEFFS  = 13;     // mfcc coeffs per frame
    localparam int WINDOW_LEN  = 5;      // frames in the regression window
    localparam int FILL_FRAMES = 3;      // frames before the first window

    // divide by ten done as multiply then shift
    localparam int TENTH_RECIP = 6554;   // round(2^16 / 10)
    localparam int TENTH_SHIFT = 16;

    ////////////////////////////////////////////////////////////////////////////
    // datapath widths
    ////////////////////////////////////////////////////////////////////////////

    typedef logic signed [15:0] coeff_t;   // input coefficient
    typedef logic signed [16:0] diff_t;    // one guard bit for a - b
    typedef logic signed [18:0] num_t;     // near + 2 * far
    typedef logic signed [33:0] prod_t;    // num * TENTH_RECIP
    typedef logic signed [17:0] delta_t;   // prod >>> TENTH_SHIFT

    typedef logic [3:0] coeff_idx_t;       // 0 .. NUM_COEFFS-1

    // history fsm
    typedef enum logic [2:0] {
        FILL_FIRST,
        FILL_SECOND,
        FILL_THIRD,
        PAD_OLDEST,
        WINDOW_READY,
        WAIT_FRAME
    } hist_state_t;

endpackage

/* hdl/frame_collector.sv */
`timescale 1ns/1ps

module frame_collector import delta_pkg::*; (
    input  logic   clk,
    input  logic   rst,

    input  logic   in_valid,
    input  coeff_t in_coeff,
    output logic   in_ready,

    output logic   frame_valid,
    output coeff_t frame_coeffs [NUM_COEFFS],
    input  logic   frame_ready
);

    localparam coeff_idx_t LAST_IDX = coeff_idx_t'(NUM_COEFFS - 1);

    coeff_idx_t coeff_cnt;   // slot for next coeff
    logic       in_xfer;

    assign in_ready = !frame_valid;   // closed while a full frame waits
    assign in_xfer  = in_valid && in_ready;

    ////////////////////////////////////////////////////////////////////////////
    // count coefficients, flag a complete frame
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            coeff_cnt   <= '0;
            frame_valid <= 1'b0;
        end else begin
            if (in_xfer) begin
                if (coeff_cnt == LAST_IDX) begin
                    coeff_cnt   <= '0;
                    frame_valid <= 1'b1;   // 13th coeff in
                end else begin
                    coeff_cnt <= coeff_cnt + 1'b1;
                end
            end else if (frame_valid && frame_ready) begin
                frame_valid <= 1'b0;
            end
        end
    end

    // coeffs land directly at their index
    always_ff @(posedge clk) begin
        if (in_xfer) begin
            frame_coeffs[coeff_cnt] <= in_coeff;
        end
    end

endmodule

/* hdl/frame_history.sv */
`timescale 1ns/1ps

module frame_history import delta_pkg::*; (
    input  logic   clk,
    input  logic   rst,

    input  logic   frame_valid,
    input  coeff_t frame_coeffs [NUM_COEFFS],
    output logic   frame_ready,

    output logic   window_valid,
    output coeff_t window_pages [WINDOW_LEN][NUM_COEFFS],
    input  logic   window_ready
);

    hist_state_t state;
    logic        frame_xfer;

    // frames only enter while no window is on offer
    always_comb begin
        case (state)
            FILL_FIRST, FILL_SECOND, FILL_THIRD, WAIT_FRAME: frame_ready = 1'b1;
            default:                                         frame_ready = 1'b0;
        endcase
    end

    assign window_valid = (state == WINDOW_READY);
    assign frame_xfer   = frame_valid && frame_ready;

    ////////////////////////////////////////////////////////////////////////////
    // history fsm
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FILL_FIRST;
        end else begin
            case (state)
                FILL_FIRST: begin
                    if (frame_xfer) begin
                        state <= FILL_SECOND;
                    end
                end
                FILL_SECOND: begin
                    if (frame_xfer) begin
                        state <= FILL_THIRD;
                    end
                end
                FILL_THIRD: begin
                    if (frame_xfer) begin
                        state <= PAD_OLDEST;
                    end
                end
                PAD_OLDEST: begin
                    state <= WINDOW_READY;   // pad takes one cycle
                end
                WINDOW_READY: begin
                    if (window_ready) begin
                        state <= WAIT_FRAME;
                    end
                end
                WAIT_FRAME: begin
                    if (frame_xfer) begin
                        state <= WINDOW_READY;
                    end
                end
                default: begin
                    state <= FILL_FIRST;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // pages, 0 newest
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int p = 0; p < WINDOW_LEN; p++) begin
                for (int k = 0; k < NUM_COEFFS; k++) begin
                    window_pages[p][k] <= '0;
                end
            end
        end else if (frame_xfer) begin
            window_pages[0] <= frame_coeffs;
            for (int p = 1; p < WINDOW_LEN; p++) begin
                window_pages[p] <= window_pages[p-1];   // age by one
            end
        end else if (state == PAD_OLDEST) begin
            // first frame fills the slots no real frame reached yet
            for (int p = FILL_FRAMES; p < WINDOW_LEN; p++) begin
                window_pages[p] <= window_pages[FILL_FRAMES-1];
            end
        end
    end

endmodule

/* hdl/coeff_sequencer.sv */
`timescale 1ns/1ps

module coeff_sequencer import delta_pkg::*; (
    input  logic   clk,
    input  logic   rst,

    input  logic   window_valid,
    input  coeff_t window_pages [WINDOW_LEN][NUM_COEFFS],
    output logic   window_ready,

    output logic   col_valid,
    output coeff_t col_p0,
    output coeff_t col_p1,
    output coeff_t col_p2,
    output coeff_t col_p3,
    output coeff_t col_p4,
    input  logic   col_ready
);

    localparam coeff_idx_t LAST_IDX = coeff_idx_t'(NUM_COEFFS - 1);

    coeff_t     win_buf [WINDOW_LEN][NUM_COEFFS];   // private copy of the window
    coeff_idx_t col_idx;
    logic       win_xfer;
    logic       col_xfer;

    assign window_ready = !col_valid;   // idle between windows
    assign win_xfer     = window_valid && window_ready;
    assign col_xfer     = col_valid && col_ready;

    // current column always sits at index 0
    assign col_p0 = win_buf[0][0];
    assign col_p1 = win_buf[1][0];
    assign col_p2 = win_buf[2][0];
    assign col_p3 = win_buf[3][0];
    assign col_p4 = win_buf[4][0];

    always_ff @(posedge clk) begin
        if (rst) begin
            col_valid <= 1'b0;
            col_idx   <= '0;
        end else if (win_xfer) begin
            col_valid <= 1'b1;
            col_idx   <= '0;
        end else if (col_xfer) begin
            if (col_idx == LAST_IDX) begin
                col_valid <= 1'b0;   // window done
                col_idx   <= '0;
            end else begin
                col_idx <= col_idx + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // window buffer, load then shift toward index 0
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (win_xfer) begin
            for (int p = 0; p < WINDOW_LEN; p++) begin
                win_buf[p] <= window_pages[p];
            end
        end else if (col_xfer) begin
            for (int p = 0; p < WINDOW_LEN; p++) begin
                for (int k = 0; k < NUM_COEFFS - 1; k++) begin
                    win_buf[p][k] <= win_buf[p][k+1];
                end
            end
        end
    end

endmodule

/* hdl/delta_datapath.sv */
`timescale 1ns/1ps

module delta_datapath import delta_pkg::*; (
    input  logic   clk,
    input  logic   rst,

    input  logic   col_valid,
    input  coeff_t col_p0,
    input  coeff_t col_p1,
    input  coeff_t col_p2,
    input  coeff_t col_p3,
    input  coeff_t col_p4,
    output logic   col_ready,

    output logic   out_valid,
    output delta_t out_delta,
    input  logic   out_ready
);

    logic  pipe_en;    // low freezes all three stages
    logic  s1_valid;
    logic  s2_valid;
    diff_t s1_near;    // p1 - p3
    diff_t s1_far;     // p0 - p4
    num_t  s2_num;
    prod_t s3_prod;

    assign pipe_en   = out_ready;
    assign col_ready = pipe_en;

    assign s3_prod = prod_t'(s2_num) * prod_t'(TENTH_RECIP);

    ////////////////////////////////////////////////////////////////////////////
    // valid bits
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else if (pipe_en) begin
            s1_valid  <= col_valid;
            s2_valid  <= s1_valid;
            out_valid <= s2_valid;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // arithmetic stages
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (pipe_en) begin
            s1_near   <= diff_t'(col_p1) - diff_t'(col_p3);
            s1_far    <= diff_t'(col_p0) - diff_t'(col_p4);
            s2_num    <= num_t'(s1_near) + (num_t'(s1_far) <<< 1);
            out_delta <= delta_t'(s3_prod >>> TENTH_SHIFT);   // num scaled by one tenth
        end
    end

endmodule

/* hdl/delta_top.sv */
`timescale 1ns/1ps

module delta_top import delta_pkg::*; (
    input  logic   clk,
    input  logic   rst,

    input  logic   in_valid,
    input  coeff_t in_coeff,
    output logic   in_ready,

    output logic   out_valid,
    output delta_t out_delta,
    input  logic   out_ready
);

    // collector -> history
    logic   frame_valid;
    logic   frame_ready;
    coeff_t frame_coeffs [NUM_COEFFS];

    // history -> sequencer
    logic   window_valid;
    logic   window_ready;
    coeff_t window_pages [WINDOW_LEN][NUM_COEFFS];

    // sequencer -> datapath
    logic   col_valid;
    logic   col_ready;
    coeff_t col_p0;
    coeff_t col_p1;
    coeff_t col_p2;
    coeff_t col_p3;
    coeff_t col_p4;

    ////////////////////////////////////////////////////////////////////////////
    // frame assembly and history
    ////////////////////////////////////////////////////////////////////////////

    frame_collector frame_collector_inst (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_coeff     (in_coeff),
        .in_ready     (in_ready),
        .frame_valid  (frame_valid),
        .frame_coeffs (frame_coeffs),
        .frame_ready  (frame_ready)
    );

    frame_history frame_history_inst (
        .clk          (clk),
        .rst          (rst),
        .frame_valid  (frame_valid),
        .frame_coeffs (frame_coeffs),
        .frame_ready  (frame_ready),
        .window_valid (window_valid),
        .window_pages (window_pages),
        .window_ready (window_ready)
    );

    ////////////////////////////////////////////////////////////////////////////
    // per-coefficient walk and arithmetic
    ////////////////////////////////////////////////////////////////////////////

    coeff_sequencer coeff_sequencer_inst (
        .clk          (clk),
        .rst          (rst),
        .window_valid (window_valid),
        .window_pages (window_pages),
        .window_ready (window_ready),
        .col_valid    (col_valid),
        .col_p0       (col_p0),
        .col_p1       (col_p1),
        .col_p2       (col_p2),
        .col_p3       (col_p3),
        .col_p4       (col_p4),
        .col_ready    (col_ready)
    );

    delta_datapath delta_datapath_inst (
        .clk       (clk),
        .rst       (rst),
        .col_valid (col_valid),
        .col_p0    (col_p0),
        .col_p1    (col_p1),
        .col_p2    (col_p2),
        .col_p3    (col_p3),
        .col_p4    (col_p4),
        .col_ready (col_ready),
        .out_valid (out_valid),
        .out_delta (out_delta),
        .out_ready (out_ready)
    );

endmodule

/* verif/delta_properties.sv */
`timescale 1ns/1ps

module delta_properties import delta_pkg::*; (
    input logic   clk,
    input logic   rst,
    input logic   in_valid,
    input coeff_t in_coeff,
    input logic   out_valid,
    input delta_t out_delta,
    input logic   out_ready
);

    // pipeline comes out of reset empty
    out_low_after_reset: assert property (@(posedge clk) rst |=> !out_valid)
        else $error("out_valid high after reset");

    out_held_when_stalled: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_delta)))
        else $error("output changed while out_ready low");

    in_coeff_known: assert property (@(posedge clk) disable iff (rst)
        in_valid |-> !$isunknown(in_coeff))
        else $error("in_coeff unknown while in_valid high");

endmodule

/* verif/delta_tb.sv */
`timescale 1ns/1ps

module delta_tb import delta_pkg::*; ();

    localparam int TIMEOUT = 2000;   // cycles per wait

    logic   clk = 1'b0;
    logic   rst;
    logic   in_valid;
    coeff_t in_coeff;
    logic   in_ready;
    logic   out_valid;
    delta_t out_delta;
    logic   out_ready;

    coeff_t stim [8][NUM_COEFFS];             // frames of the current test
    coeff_t pages [WINDOW_LEN][NUM_COEFFS];   // model history with page 0 newest
    int     frames_seen;
    delta_t exp_q [$];
    int     checks;
    int     errors;

    delta_top delta_top_inst (.*);

    bind delta_top delta_properties delta_properties_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_coeff  (in_coeff),
        .out_valid (out_valid),
        .out_delta (out_delta),
        .out_ready (out_ready)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // window model and checks
    ////////////////////////////////////////////////////////////////////////////

    function automatic delta_t expected_delta(coeff_t p0, coeff_t p1, coeff_t p3,
                                              coeff_t p4);
        longint num;
        num = (longint'(p1) - longint'(p3)) + 2 * (longint'(p0) - longint'(p4));
        return delta_t'((num * TENTH_RECIP) >>> TENTH_SHIFT);   // scaled tenth
    endfunction

    task automatic model_frame(int f);
        for (int p = WINDOW_LEN - 1; p > 0; p--) begin
            pages[p] = pages[p-1];
        end
        pages[0] = stim[f];
        frames_seen++;
        if (frames_seen == FILL_FRAMES) begin
            pages[3] = pages[2];   // oldest frame pads the empty pages
            pages[4] = pages[2];
        end
        if (frames_seen >= FILL_FRAMES) begin
            for (int k = 0; k < NUM_COEFFS; k++) begin
                exp_q.push_back(expected_delta(pages[0][k], pages[1][k], pages[3][k],
                                               pages[4][k]));
            end
        end
    endtask

    task automatic make_frames(int n, bit extremes);
        for (int f = 0; f < n; f++) begin
            for (int k = 0; k < NUM_COEFFS; k++) begin
                stim[f][k] = coeff_t'($urandom);
                if (extremes && ((f + k) % 2 == 0)) begin
                    stim[f][k] = (f % 2 == 0) ? 16'sh7fff : 16'sh8000;
                end
            end
        end
    endtask

    task automatic check_delta(string name, delta_t want, delta_t got);
        checks++;
        if (got !== want) begin
            errors++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, want, got);
        end
    endtask

    task automatic check_ready(string name, logic want, logic got);
        checks++;
        if (got !== want) begin
            errors++;
            $display("CHECK FAILED %s in_ready: expected %0b, actual %0b", name, want, got);
        end
    endtask

    task automatic finish_run();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    task automatic timed_out(string what);
        errors++;
        $display("timeout: no progress while waiting for %s", what);
        finish_run();
    endtask

    task automatic apply_reset();
        rst       = 1'b1;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        frames_seen = 0;
        for (int p = 0; p < WINDOW_LEN; p++) begin
            for (int k = 0; k < NUM_COEFFS; k++) begin
                pages[p][k] = '0;
            end
        end
        exp_q.delete();
        check_ready("reset", 1'b1, in_ready);   // collector open after reset
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus and response
    ////////////////////////////////////////////////////////////////////////////

    task automatic send_frames(int first, int n, bit gaps);
        int waited;
        for (int f = first; f < first + n; f++) begin
            for (int k = 0; k < NUM_COEFFS; k++) begin
                if (gaps) begin
                    in_valid = 1'b0;
                    repeat ($urandom % 3) @(negedge clk);
                end
                in_valid = 1'b1;
                in_coeff = stim[f][k];
                waited   = 0;
                while (!in_ready) begin
                    @(negedge clk);
                    waited++;
                    if (waited > TIMEOUT) begin
                        timed_out("in_ready");
                    end
                end
                @(negedge clk);   // transfer on the edge in between
            end
        end
        in_valid = 1'b0;
    endtask

    task automatic collect_outputs(string name, int holdoff, bit random_ready);
        int     idle;
        delta_t want;
        out_ready = 1'b0;
        repeat (holdoff) @(negedge clk);   // let back-pressure reach in_ready
        if (holdoff > 0) begin
            check_ready(name, 1'b0, in_ready);   // source stalled by now
        end
        idle = 0;
        while (exp_q.size() > 0) begin
            out_ready = random_ready ? ($urandom % 2 == 0) : 1'b1;
            if (out_valid && out_ready) begin
                want = exp_q.pop_front();
                check_delta(name, want, out_delta);
                idle = 0;
            end else begin
                idle++;
                if (idle > TIMEOUT) begin
                    timed_out("out_valid");
                end
            end
            @(negedge clk);
        end
        out_ready = 1'b0;
    endtask

    task automatic expect_quiet(string name, int cycles);
        out_ready = 1'b1;
        repeat (cycles) begin
            @(negedge clk);
            if (out_valid) begin
                errors++;
                $display("%s: output %0d appeared where none was due", name, out_delta);
            end
        end
        out_ready = 1'b0;
    endtask

    task automatic run_frames(string name, int first, int n, bit gaps, int holdoff,
                              bit random_ready);
        for (int f = first; f < first + n; f++) begin
            model_frame(f);
        end
        fork
            send_frames(first, n, gaps);
            collect_outputs(name, holdoff, random_ready);
        join
    endtask

    // two silent frames then one window with padded pages
    task automatic test_fill(string name, int first);
        run_frames(name, first, 2, 1'b0, 0, 1'b0);
        expect_quiet(name, 40);
        run_frames(name, first + 2, 1, 1'b0, 0, 1'b0);
        expect_quiet(name, 40);
    endtask

    initial begin
        void'($urandom(95));
        checks   = 0;
        errors   = 0;
        in_coeff = '0;
        apply_reset();

        make_frames(3, 1'b0);
        test_fill("startup", 0);

        make_frames(5, 1'b1);
        run_frames("sliding", 0, 5, 1'b0, 0, 1'b0);
        make_frames(5, 1'b0);
        run_frames("backpressure", 0, 5, 1'b0, 0, 1'b1);
        make_frames(5, 1'b1);
        run_frames("gaps", 0, 5, 1'b1, 200, 1'b1);

        make_frames(4, 1'b0);
        run_frames("reset", 0, 1, 1'b0, 0, 1'b0);
        apply_reset();
        test_fill("reset", 1);

        finish_run();
    end

endmodule

/* delta_top.f */
hdl/delta_pkg.sv
hdl/frame_collector.sv
hdl/frame_history.sv
hdl/coeff_sequencer.sv
hdl/delta_datapath.sv
hdl/delta_top.sv
verif/delta_properties.sv
verif/delta_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module delta_tb -f delta_top.f -o delta_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/delta_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1
